// ==== design/ubaPkg.sv ====
// KS10 IO bridge paging package
// Word, page, flag and channel types shared by the channels, arbiter and pager
// Bit 0 is the most significant bit everywhere, as in KS10 documentation

`default_nettype none

package ubaPkg;

   //////////////////////////////////////////////////
   // Bus words and page numbers
   //////////////////////////////////////////////////

   // Full KS10 word
   // Used for device addresses, paged addresses and bus data
   typedef logic [0:35] word36_t;

   // Virtual page taken from device address bits 19 to 24
   // Also indexes the page table from bus address bits 30 to 35
   typedef logic [0:5] vpage_t;

   // Physical page placed at paged address bits 16 to 26
   typedef logic [0:10] ppage_t;

   //////////////////////////////////////////////////
   // Page table entries
   //////////////////////////////////////////////////

   // Page flags in RPW, E16, FTM, VLD order
   typedef logic [0:3] pageFlags_t;

   // Flag positions inside pageFlags_t
   localparam int FLAG_RPW = 0;   // Force read-pause-write
   localparam int FLAG_E16 = 1;   // 16-bit device transfers
   localparam int FLAG_FTM = 2;   // Fast transfer mode
   localparam int FLAG_VLD = 3;   // Entry holds a valid mapping

   // Stored entry
   // Flags in bits 0 to 3, physical page in bits 4 to 14
   typedef logic [0:14] pageEntry_t;

   //////////////////////////////////////////////////
   // Device channels and arbitration
   //////////////////////////////////////////////////

   // Number of device channels sharing the pager
   localparam int NUM_CHAN = 4;

   // Channel index, sized from the channel count
   typedef logic [$clog2(NUM_CHAN)-1:0] chanSel_t;

   // Arbiter sequence for one translation
   typedef enum logic [1:0]
   {
      IDLE,     // Waiting for any channel request
      LOOKUP,   // Granted address presented to the pager
      RETURN    // Result registered, ack held until req drops
   } arbState_t;

endpackage

`default_nettype wire

// ==== design/ubaPageIf.sv ====
// Page lookup link between one device channel and the arbiter
// Four-phase req/ack with the address on the request side and the
// paged address, flags and fail on the acknowledge side

`default_nettype none

interface ubaPageIf import ubaPkg::*; ();

   // Channel to arbiter
   logic       req;
   word36_t    addr;        // Stable while req is high

   // Arbiter to channel
   logic       ack;
   word36_t    pagedAddr;   // Stable while ack is high
   pageFlags_t flags;
   logic       fail;

   modport chan (output req, addr, input ack, pagedAddr, flags, fail);
   modport arb  (input req, addr, output ack, pagedAddr, flags, fail);

endinterface

`default_nettype wire

// ==== design/ubaChannel.sv ====
// IO bridge device channel
// Turns one device's four-phase request into a lookup request to the
// arbiter and holds the paged address, flags and fail for the device

`default_nettype none

module ubaChannel
   import ubaPkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic       devReq,
   input  word36_t    devAddr,
   output logic       devAck,
   output word36_t    devPagedAddr,
   output pageFlags_t devFlags,
   output logic       devFail,
   ubaPageIf.chan     bus
);

   // Handshake phases of the channel
   typedef enum logic [1:0]
   {
      CH_IDLE,      // No request outstanding
      CH_WAIT,      // req raised, waiting for the arbiter ack
      CH_HOLD,      // Result delivered, waiting for devReq to fall
      CH_RELEASE    // req dropped, waiting for the arbiter ack to fall
   } chanState_t;

   chanState_t state;
   logic       startReq;
   logic       gotAck;

   // Start only once the last ack from the arbiter is gone
   assign startReq = (state == CH_IDLE) && devReq && !bus.ack;

   // Result arrives with the rising ack
   assign gotAck = (state == CH_WAIT) && bus.ack;

   //////////////////////////////////////////////////
   // Handshake FSM
   //////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
         state <= CH_IDLE;
      else
      begin
         case (state)
            CH_IDLE:
               if (startReq)
                  state <= CH_WAIT;
            CH_WAIT:
               if (gotAck)
                  state <= CH_HOLD;
            // Device holds its request as long as it likes
            CH_HOLD:
               if (!devReq)
                  state <= CH_RELEASE;
            CH_RELEASE:
               if (!bus.ack)
                  state <= CH_IDLE;
            default:
               state <= CH_IDLE;
         endcase
      end
   end

   // req covers WAIT and HOLD, devAck trails it by one phase
   assign bus.req = (state == CH_WAIT) || (state == CH_HOLD);
   assign devAck  = (state == CH_HOLD) || (state == CH_RELEASE);

   //////////////////////////////////////////////////
   // Address and result registers
   //////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      // Address frozen for the whole lookup
      if (startReq)
         bus.addr <= devAddr;
      // Result kept until the next request completes
      if (gotAck)
      begin
         devPagedAddr <= bus.pagedAddr;
         devFlags     <= bus.flags;
         devFail      <= bus.fail;
      end
   end

endmodule

`default_nettype wire

// ==== design/ubaArbiter.sv ====
// Round-robin arbiter in front of the pager
// Grants one requesting channel at a time, presents its address to the
// pager and returns the registered result over that channel's handshake

`default_nettype none

module ubaArbiter
   import ubaPkg::*;
(
   input  logic       clk,
   input  logic       reset,
   ubaPageIf.arb      chan [NUM_CHAN],
   output word36_t    lookAddr,
   input  word36_t    lookPagedAddr,
   input  pageFlags_t lookFlags,
   input  logic       lookFail
);

   arbState_t           state;
   chanSel_t            grant;       // Current or last granted channel
   chanSel_t            nextGrant;
   logic                anyReq;
   logic [NUM_CHAN-1:0] reqVec;
   logic [NUM_CHAN-1:0] ackReg;
   word36_t             addrVec  [NUM_CHAN];
   word36_t             resAddr  [NUM_CHAN];
   pageFlags_t          resFlags [NUM_CHAN];
   logic                resFail  [NUM_CHAN];

   // Flatten the interface array so it can be indexed by grant
   for (genvar i = 0; i < NUM_CHAN; i++)
   begin : g_chan
      assign reqVec[i]         = chan[i].req;
      assign addrVec[i]        = chan[i].addr;
      assign chan[i].ack       = ackReg[i];
      assign chan[i].pagedAddr = resAddr[i];
      assign chan[i].flags     = resFlags[i];
      assign chan[i].fail      = resFail[i];
   end

   assign anyReq = |reqVec;

   //////////////////////////////////////////////////
   // Rotating priority
   //////////////////////////////////////////////////

   // Search from the channel after the last grant
   // Smallest distance wins, the last granted channel comes last
   always_comb
   begin
      chanSel_t cand;
      nextGrant = grant;
      for (int k = NUM_CHAN; k > 0; k--)
      begin
         cand = chanSel_t'(int'(grant) + k);
         if (reqVec[cand])
            nextGrant = cand;
      end
   end

   //////////////////////////////////////////////////
   // Grant FSM
   //////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state  <= IDLE;
         grant  <= '0;
         ackReg <= '0;
      end
      else
      begin
         case (state)
            IDLE:
               if (anyReq)
               begin
                  grant <= nextGrant;
                  state <= LOOKUP;
               end
            // Pager answers combinationally during this cycle
            LOOKUP:
            begin
               ackReg[grant] <= 1'b1;
               state         <= RETURN;
            end
            // Others wait until this handshake closes
            RETURN:
               if (!reqVec[grant])
               begin
                  ackReg[grant] <= 1'b0;
                  state         <= IDLE;
               end
            default:
               state <= IDLE;
         endcase
      end
   end

   // Pager only sees an address while a lookup is in progress
   assign lookAddr = (state == LOOKUP) ? addrVec[grant] : '0;

   // Capture pager outputs for the granted channel
   always_ff @(posedge clk)
   begin
      if (state == LOOKUP)
      begin
         resAddr[grant]  <= lookPagedAddr;
         resFlags[grant] <= lookFlags;
         resFail[grant]  <= lookFail;
      end
   end

endmodule

`default_nettype wire

// ==== design/ubaPager.sv ====
// IO bridge page table and address translation
// 64-entry page RAM with a KS10 write/read port and a read-only
// device port that maps a virtual page to a physical page

`default_nettype none

module ubaPager
   import ubaPkg::*;
(
   input  logic       clk,
   input  logic       pageWrite,
   input  word36_t    busAddr,
   input  word36_t    busData,
   output word36_t    pageData,
   input  logic       maint,
   input  word36_t    lookAddr,
   output word36_t    lookPagedAddr,
   output pageFlags_t lookFlags,
   output logic       lookFail
);

   // Device address layout
   //
   //   18   19 .. 24    25 .. 33    34  35
   //   A17  virt page   word        W   B
   //
   // Paged address layout
   //
   //   0 .. 15          16 .. 26    27 .. 35
   //   device bits      phys page   word

   //////////////////////////////////////////////////
   // Page RAM
   //////////////////////////////////////////////////

   // One entry per virtual page, loaded by software
   pageEntry_t pageRam [2**$bits(vpage_t)];

   vpage_t     busPage;
   vpage_t     virtPage;
   pageEntry_t busEntry;
   pageEntry_t devEntry;
   ppage_t     physPage;

   // KS10 side indexes with the low address bits
   assign busPage = busAddr[30:35];

   // Device side indexes with the virtual page field
   assign virtPage = lookAddr[19:24];

   // Flags from data bits 18 to 21, page from bits 25 to 35
   always_ff @(posedge clk)
   begin
      if (pageWrite)
         pageRam[busPage] <= {busData[18:21], busData[25:35]};
   end

   // Two independent read ports
   assign busEntry = pageRam[busPage];
   assign devEntry = pageRam[virtPage];

   //////////////////////////////////////////////////
   // KS10 readback
   //////////////////////////////////////////////////

   // Flags land in bits 5 to 8, page in bits 16 to 26
   // Everything else reads as zero
   assign pageData = {5'b0, busEntry[0:3], 7'b0, busEntry[4:14], 9'b0};

   //////////////////////////////////////////////////
   // Device translation
   //////////////////////////////////////////////////

   assign physPage  = devEntry[4:14];
   assign lookFlags = devEntry[0:3];

   // High bits pass through, word number keeps its place
   // Bits 34 and 35 select halves and are dropped
   assign lookPagedAddr = {lookAddr[0:15], physPage, lookAddr[25:33]};

   // Page fail conditions
   // A17 set means the device is out of the mapped range
   // Unaligned word or byte select only allowed in maintenance mode
   // Entry not loaded
   assign lookFail = lookAddr[18] |
                     (!maint & (lookAddr[34] | lookAddr[35])) |
                     !lookFlags[FLAG_VLD];

endmodule

`default_nettype wire

// ==== design/ubaBridge.sv ====
// IO bridge paging top level
// Device channels share one page table through a round-robin arbiter
// while the KS10 side loads and reads back page entries

`default_nettype none

module ubaBridge
   import ubaPkg::*;
(
   input  logic       clk,
   input  logic       reset,

   // Device DMA address ports
   input  logic       devReq       [NUM_CHAN],
   input  word36_t    devAddr      [NUM_CHAN],
   output logic       devAck       [NUM_CHAN],
   output word36_t    devPagedAddr [NUM_CHAN],
   output pageFlags_t devFlags     [NUM_CHAN],
   output logic       devFail      [NUM_CHAN],

   // KS10 page table access
   input  logic       pageWrite,
   input  word36_t    busAddr,
   input  word36_t    busData,
   output word36_t    pageData,

   // Maintenance mode bit
   input  logic       maint
);

   // One lookup link per channel
   ubaPageIf pageBus [NUM_CHAN] ();

   // Translation port between arbiter and pager
   word36_t    lookAddr;
   word36_t    lookPagedAddr;
   pageFlags_t lookFlags;
   logic       lookFail;

   //////////////////////////////////////////////////
   // Device channels
   //////////////////////////////////////////////////

   for (genvar i = 0; i < NUM_CHAN; i++)
   begin : g_chan
      ubaChannel i_ubaChannel
      (
         .clk          (clk),
         .reset        (reset),
         .devReq       (devReq[i]),
         .devAddr      (devAddr[i]),
         .devAck       (devAck[i]),
         .devPagedAddr (devPagedAddr[i]),
         .devFlags     (devFlags[i]),
         .devFail      (devFail[i]),
         .bus          (pageBus[i])
      );
   end

   //////////////////////////////////////////////////
   // Arbiter and pager
   //////////////////////////////////////////////////

   ubaArbiter i_ubaArbiter
   (
      .clk           (clk),
      .reset         (reset),
      .chan          (pageBus),
      .lookAddr      (lookAddr),
      .lookPagedAddr (lookPagedAddr),
      .lookFlags     (lookFlags),
      .lookFail      (lookFail)
   );

   ubaPager i_ubaPager
   (
      .clk           (clk),
      .pageWrite     (pageWrite),
      .busAddr       (busAddr),
      .busData       (busData),
      .pageData      (pageData),
      .maint         (maint),
      .lookAddr      (lookAddr),
      .lookPagedAddr (lookPagedAddr),
      .lookFlags     (lookFlags),
      .lookFail      (lookFail)
   );

endmodule

`default_nettype wire

// ==== testbench/ubaBridge_asserts.sv ====
// Handshake checks for the IO bridge channels and arbiter
// Four-phase req/ack order per link, and a single grant at a time

`default_nettype none

module ubaBridge_asserts
#(
   parameter int WIDTH = 1
)
(
   input logic             clk,
   input logic             reset,
   input logic [WIDTH-1:0] req,
   input logic [WIDTH-1:0] ack
);

   for (genvar i = 0; i < WIDTH; i++)
   begin : g_link
      // New request only once the last ack is gone
      reqAfterAck : assert property (@(posedge clk) disable iff (reset)
                                     $rose(req[i]) |-> !ack[i])
         else $error("req raised on link %0d while ack still high", i);

      // Ack answers a request that was live when ack was raised
      ackOnReq : assert property (@(posedge clk) disable iff (reset)
                                  $rose(ack[i]) |-> $past(req[i]))
         else $error("ack rose on link %0d without a request", i);
   end

   //////////////////////////////////////////////////
   // Single grant
   //////////////////////////////////////////////////

   // Only the arbiter side has several links competing
   if (WIDTH > 1)
   begin : g_grant
      oneGrant : assert property (@(posedge clk) disable iff (reset) $onehot0(ack))
         else $error("more than one link acknowledged at once");
   end

endmodule

// Pin-level handshake of every channel
bind ubaChannel ubaBridge_asserts #(.WIDTH(1)) i_chanAsserts
(
   .clk   (clk),
   .reset (reset),
   .req   (devReq),
   .ack   (devAck)
);

// Interface handshakes seen by the arbiter
bind ubaArbiter ubaBridge_asserts #(.WIDTH(ubaPkg::NUM_CHAN)) i_arbAsserts
(
   .clk   (clk),
   .reset (reset),
   .req   (reqVec),
   .ack   (ackReg)
);

`default_nettype wire

// ==== testbench/ubaBridgeTb.sv ====
// IO bridge paging testbench
// Loads the page table from the KS10 side, runs device lookups on every
// channel and compares each result with a reference model of the rules

`default_nettype none

module ubaBridgeTb
   import ubaPkg::*;
();

   // Expected outcome of one device lookup
   typedef struct packed
   {
      word36_t    pagedAddr;
      pageFlags_t flags;
      logic       fail;
   } lookup_t;

   localparam int SINGLE_REQS   = 32;
   localparam int REQS_PER_CHAN = 40;
   // Cycles a device waits on devAck before it gives up
   localparam int ACK_LIMIT     = 100;
   // About 200 lookups at up to 10 cycles each plus table traffic, doubled
   localparam int MAX_CYCLES    = 4000;

   logic       clk;
   logic       reset;
   logic       devReq       [NUM_CHAN];
   word36_t    devAddr      [NUM_CHAN];
   logic       devAck       [NUM_CHAN];
   word36_t    devPagedAddr [NUM_CHAN];
   pageFlags_t devFlags     [NUM_CHAN];
   logic       devFail      [NUM_CHAN];
   logic       pageWrite;
   word36_t    busAddr;
   word36_t    busData;
   word36_t    pageData;
   logic       maint;

   integer     seed;
   pageEntry_t shadow     [64];
   word36_t    pendAddr   [NUM_CHAN];   // Address each device last requested
   int         issueCount [NUM_CHAN];
   int         doneCount  [NUM_CHAN];
   logic       lastAck    [NUM_CHAN];
   word36_t    trafAddr   [NUM_CHAN][REQS_PER_CHAN];
   int         trafHold   [NUM_CHAN][REQS_PER_CHAN];
   int         errors;
   int         checks;
   int         cmpErrors;
   int         cmpChecks;
   int         cycleCount;

   ubaBridge i_ubaBridge
   (
      .clk          (clk),
      .reset        (reset),
      .devReq       (devReq),
      .devAddr      (devAddr),
      .devAck       (devAck),
      .devPagedAddr (devPagedAddr),
      .devFlags     (devFlags),
      .devFail      (devFail),
      .pageWrite    (pageWrite),
      .busAddr      (busAddr),
      .busData      (busData),
      .pageData     (pageData),
      .maint        (maint)
   );

   always #10 clk = ~clk;

   // Run limit
   always @(posedge clk)
   begin
      cycleCount++;
      if (cycleCount >= MAX_CYCLES)
      begin
         $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

   //////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////

   function automatic word36_t randWord();
      logic [31:0] lo;
      logic [3:0]  hi;
      lo = $random(seed);
      hi = 4'($random(seed));
      return {hi, lo};
   endfunction

   // Device address with chosen page, A17 and low select bits
   function automatic word36_t makeAddr(input vpage_t vp, input logic a17,
                                        input logic [1:0] low);
      word36_t a;
      a        = randWord();
      a[18]    = a17;
      a[19:24] = vp;
      a[34:35] = low;
      return a;
   endfunction

   // High device bits, physical page, word number
   function automatic lookup_t pagedModel(input word36_t addr, input pageEntry_t entry,
                                          input logic mnt);
      lookup_t r;
      r.pagedAddr = {addr[0:15], entry[4:14], addr[25:33]};
      r.flags     = entry[0:3];
      r.fail      = addr[18] || (!mnt && (addr[34] || addr[35])) || !entry[FLAG_VLD];
      return r;
   endfunction

   // KS10 readback layout of one entry
   function automatic word36_t readbackWord(input pageEntry_t entry);
      return {5'b0, entry[0:3], 7'b0, entry[4:14], 9'b0};
   endfunction

   //////////////////////////////////////////////////
   // Result comparison
   //////////////////////////////////////////////////

   task automatic compareResult(input int c);
      lookup_t want;
      want = pagedModel(pendAddr[c], shadow[pendAddr[c][19:24]], maint);
      doneCount[c]++;
      cmpChecks++;
      if (devPagedAddr[c] !== want.pagedAddr)
      begin
         $display("FAILED at %0t: channel %0d address %012o paged to %012o, expected %012o",
                  $time, c, pendAddr[c], devPagedAddr[c], want.pagedAddr);
         cmpErrors++;
      end
      if (devFlags[c] !== want.flags)
      begin
         $display("FAILED at %0t: channel %0d flags %b, expected %b",
                  $time, c, devFlags[c], want.flags);
         cmpErrors++;
      end
      if (devFail[c] !== want.fail)
      begin
         $display("FAILED at %0t: channel %0d fail %b, expected %b",
                  $time, c, devFail[c], want.fail);
         cmpErrors++;
      end
   endtask

   // Each channel checked on its rising devAck, mid cycle
   always @(negedge clk)
   begin
      for (int c = 0; c < NUM_CHAN; c++)
      begin
         if (reset)
         begin
            lastAck[c]   = 1'b0;
            doneCount[c] = 0;
         end
         else
         begin
            if (devAck[c] && !lastAck[c])
               compareResult(c);
            lastAck[c] = devAck[c];
         end
      end
   end

   //////////////////////////////////////////////////
   // Stimulus tasks
   //////////////////////////////////////////////////

   // Flags from data bits 18 to 21, page from 25 to 35
   task automatic writeEntry(input vpage_t idx, input word36_t data);
      word36_t a;
      a          = randWord();
      a[30:35]   = idx;
      busAddr    = a;
      busData    = data;
      pageWrite  = 1'b1;
      shadow[idx] = {data[18:21], data[25:35]};
      @(negedge clk);
      pageWrite  = 1'b0;
   endtask

   task automatic readCheck(input vpage_t idx);
      word36_t a;
      word36_t want;
      a        = randWord();
      a[30:35] = idx;
      busAddr  = a;
      want     = readbackWord(shadow[idx]);
      @(negedge clk);
      checks++;
      if (pageData !== want)
      begin
         $display("FAILED at %0t: page %0d read %012o, expected %012o",
                  $time, idx, pageData, want);
         errors++;
      end
   endtask

   // One full four-phase device handshake
   task automatic deviceRequest(input int ch, input word36_t addr, input int hold);
      int waited;
      waited       = 0;
      pendAddr[ch] = addr;
      devAddr[ch]  = addr;
      devReq[ch]   = 1'b1;
      issueCount[ch]++;
      while (devAck[ch] !== 1'b1 && waited < ACK_LIMIT)
      begin
         @(negedge clk);
         waited++;
      end
      if (devAck[ch] !== 1'b1)
      begin
         $display("Channel %0d never acknowledged the request for %012o", ch, addr);
         errors++;
      end
      // Device keeps its request a little longer
      repeat (hold) @(negedge clk);
      devReq[ch] = 1'b0;
      waited     = 0;
      while (devAck[ch] !== 1'b0 && waited < ACK_LIMIT)
      begin
         @(negedge clk);
         waited++;
      end
      if (devAck[ch] !== 1'b0)
      begin
         $display("Channel %0d kept devAck high after the request was released", ch);
         errors++;
      end
   endtask

   task automatic expectFail(input int ch, input logic want, input string what);
      checks++;
      if (devFail[ch] !== want)
      begin
         $display("FAILED at %0t: channel %0d fail %b for %s, expected %b",
                  $time, ch, devFail[ch], what, want);
         errors++;
      end
   endtask

   task automatic channelTraffic(input int ch);
      for (int n = 0; n < REQS_PER_CHAN; n++)
      begin
         deviceRequest(ch, trafAddr[ch][n], trafHold[ch][n]);
         repeat (trafHold[ch][n]) @(negedge clk);
      end
   endtask

   task automatic reportTest(input int num, input string name, input int startErr);
      int newErr;
      newErr = errors + cmpErrors - startErr;
      if (newErr == 0)
         $display("Test %0d %s: passed", num, name);
      else
         $display("Test %0d %s: failed with %0d errors", num, name, newErr);
   endtask

   //////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////

   initial
   begin
      int      ch;
      int      errStart;
      word36_t data;
      seed      = 4151;
      clk       = 1'b0;
      reset     = 1'b1;
      pageWrite = 1'b0;
      busAddr   = '0;
      busData   = '0;
      maint     = 1'b0;
      errors    = 0;
      checks    = 0;
      for (int c = 0; c < NUM_CHAN; c++)
      begin
         devReq[c]     = 1'b0;
         devAddr[c]    = '0;
         pendAddr[c]   = '0;
         issueCount[c] = 0;
      end
      repeat (4) @(negedge clk);
      reset = 1'b0;

      // No acknowledge without a request
      errStart = errors + cmpErrors;
      repeat (10)
      begin
         @(negedge clk);
         for (int c = 0; c < NUM_CHAN; c++)
         begin
            checks++;
            if (devAck[c] !== 1'b0)
            begin
               $display("FAILED at %0t: devAck %0d high with no request", $time, c);
               errors++;
            end
         end
      end
      reportTest(1, "idle after reset", errStart);

      errStart = errors + cmpErrors;
      for (int i = 0; i < 64; i++)
         writeEntry(vpage_t'(i), randWord());
      for (int i = 0; i < 64; i++)
         readCheck(vpage_t'(i));
      reportTest(2, "page table readback", errStart);

      // Reload every entry as valid
      errStart = errors + cmpErrors;
      for (int i = 0; i < 64; i++)
      begin
         data                = randWord();
         data[18 + FLAG_VLD] = 1'b1;
         writeEntry(vpage_t'(i), data);
      end
      for (int n = 0; n < SINGLE_REQS; n++)
      begin
         ch = $random(seed) & (NUM_CHAN - 1);
         deviceRequest(ch, makeAddr(vpage_t'($random(seed)), 1'b0, 2'b00),
                       $random(seed) & 3);
         expectFail(ch, 1'b0, "aligned address on a valid entry");
      end
      reportTest(3, "single channel translation", errStart);

      errStart            = errors + cmpErrors;
      data                = randWord();
      data[18 + FLAG_VLD] = 1'b0;
      writeEntry(6'd5, data);
      deviceRequest(1, makeAddr(6'd5, 1'b0, 2'b00), 0);
      expectFail(1, 1'b1, "entry with VLD clear");
      deviceRequest(2, makeAddr(6'd6, 1'b1, 2'b00), 1);
      expectFail(2, 1'b1, "address bit 18 set");
      deviceRequest(3, makeAddr(6'd7, 1'b0, 2'b10), 2);
      expectFail(3, 1'b1, "bit 34 set with maint low");
      deviceRequest(0, makeAddr(6'd8, 1'b0, 2'b01), 0);
      expectFail(0, 1'b1, "bit 35 set with maint low");
      maint = 1'b1;
      deviceRequest(1, makeAddr(6'd9, 1'b0, 2'b10), 1);
      expectFail(1, 1'b0, "bit 34 set with maint high");
      deviceRequest(2, makeAddr(6'd10, 1'b0, 2'b01), 0);
      expectFail(2, 1'b0, "bit 35 set with maint high");
      maint = 1'b0;
      reportTest(4, "page fail conditions", errStart);

      // Stimulus drawn up front so the forked devices share no random state
      errStart = errors + cmpErrors;
      for (int c = 0; c < NUM_CHAN; c++)
      begin
         for (int n = 0; n < REQS_PER_CHAN; n++)
         begin
            trafAddr[c][n] = randWord();
            trafHold[c][n] = $random(seed) & 3;
         end
      end
      fork
         channelTraffic(0);
         channelTraffic(1);
         channelTraffic(2);
         channelTraffic(3);
      join
      for (int c = 0; c < NUM_CHAN; c++)
      begin
         checks++;
         if (doneCount[c] != issueCount[c])
         begin
            $display("FAILED at %0t: channel %0d completed %0d of %0d requests",
                     $time, c, doneCount[c], issueCount[c]);
            errors++;
         end
      end
      reportTest(5, "overlapping channel traffic", errStart);

      $display("Summary: %0d checks, %0d errors", checks + cmpChecks, errors + cmpErrors);
      if (errors + cmpErrors == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// ==== ubaBridge.f ====
design/ubaPkg.sv
design/ubaPageIf.sv
design/ubaChannel.sv
design/ubaArbiter.sv
design/ubaPager.sv
design/ubaBridge.sv
testbench/ubaBridge_asserts.sv
testbench/ubaBridgeTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the IO bridge paging testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   -f ubaBridge.f --top-module ubaBridgeTb -o ubaBridgeSim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

simOut=$(./obj_dir/ubaBridgeSim)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
   echo "Simulation exited with status $simStatus"
   exit 1
fi

if grep -q "Simulation finished: PASS" <<< "$simOut"; then
   echo "Run passed"
   exit 0
else
   echo "Run failed"
   exit 1
fi
